// ==== list.f ====
+incdir+source
source/icache_pkg.sv
source/icache_ctrl.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_victim_sel.sv
source/icache.sv
sim/tb_clock.sv
sim/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  # Package and RTL, package first
  - include_dirs:
      - source
    files:
      - source/icache_pkg.sv
      - source/icache_ctrl.sv
      - source/icache_tag_array.sv
      - source/icache_data_array.sv
      - source/icache_victim_sel.sv
      - source/icache.sv
  # Testbench
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_clock.sv
      - sim/tb_icache.sv

// ==== sim/tb_icache.sv ====
// Self-checking testbench with a random-latency burst memory and a residency model
// Each operation starts only once the cache is idle, so hit latency is measurable
// Memory doubleword at address A holds {~A, A}

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module tb_icache import icache_pkg::*; ();

	localparam int NUM_OPS = 300;
	localparam int POOL = 8;
	localparam int WAIT_LIMIT = 200;
	localparam real WATCHDOG_NS = NUM_OPS * 60 * 4.0;

	logic CLK, rst_n, req_valid, req_ready, rsp_valid, fence, fence_end;
	logic ar_valid, ar_ready, r_valid, r_ready;
	addr_t req_addr;
	word_t rsp_data;
	ar_chan_t ar;
	r_beat_t r;

	integer seed;
	int mismatches, failures, n_fetch, n_fence;
	// Bus state written on the rising edge and read on the falling edge
	logic bus_busy = 1'b0;
	logic bus_new = 1'b0;
	logic ar_wait = 1'b0;
	logic ar_valid_q = 1'b0;
	addr_t bus_line;
	int bus_beat, bus_delay, ar_rises, rsp_count, fence_ends;
	// Line pool, operation list and residency model
	addr_t pool [POOL];
	addr_t op_addr [NUM_OPS];
	logic op_fence [NUM_OPS];
	logic filled [POOL];
	int set_fills [`ICACHE_SETS];

	tb_clock u_clk (.CLK(CLK));

	icache UUT (
		.CLK(CLK), .rst_n(rst_n), .req_valid(req_valid), .req_addr(req_addr),
		.req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
		.fence(fence), .fence_end(fence_end), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.ar(ar), .r_valid(r_valid), .r_ready(r_ready), .r(r)
	);

	function automatic word_t mem_word(addr_t a);
		addr_t dw;
		dw = {a[31:3], 3'b000};
		return {~dw, dw};
	endfunction

	function automatic int pool_index(addr_t a);
		for (int i = 0; i < POOL; i++)
			if (pool[i] == {a[31:5], 5'b0})
				return i;
		return 0;
	endfunction

	task automatic report_mismatch(input string msg);
		mismatches++;
		$display("error %0t: %s", $time, msg);
	endtask

	task automatic note_failure(input string msg);
		failures++;
		$display("Failure at %0t: %s", $time, msg);
	endtask

	// Bus and fetch-side monitor sampling the values present just before each edge
	always @(posedge CLK) begin
		if (rst_n) begin
			if (ar_wait)
				assert (ar_valid) else note_failure("ar_valid dropped before the bus took it");
			ar_wait = ar_valid && !ar_ready;
			if (ar_valid && !ar_valid_q)
				ar_rises++;
			ar_valid_q = ar_valid;
			if (ar_valid && ar_ready) begin
				assert (ar.addr == {req_addr[31:5], 5'b0} && ar.len == `ICACHE_LINE_BEATS - 1
					&& ar.burst == 2'b01)
				else report_mismatch($sformatf("burst %h len %0d type %0d for fetch %h",
					ar.addr, ar.len, ar.burst, req_addr));
				bus_busy = 1'b1;
				bus_new = 1'b1;
				bus_line = ar.addr;
				bus_beat = 0;
			end
			if (r_valid && r_ready) begin
				bus_beat++;
				if (r.last)
					bus_busy = 1'b0;
			end
			assert (req_ready == rsp_valid) else report_mismatch("req_ready differs from rsp_valid");
			if (rsp_valid) begin
				rsp_count++;
				assert (req_valid) else note_failure("response came with no fetch pending");
				assert (rsp_data == mem_word(req_addr))
				else report_mismatch($sformatf("fetch %h got %h, expected %h",
					req_addr, rsp_data, mem_word(req_addr)));
			end
			if (fence_end)
				fence_ends++;
		end
	end

	// Memory model with a start delay, then beats with random gaps
	initial begin
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r = '0;
		// Bus stays quiet until reset is released
		@(posedge rst_n);
		forever begin
			@(negedge CLK);
			ar_ready = !bus_busy && ({$random(seed)} % 3 != 0);
			if (bus_new) begin
				bus_delay = {$random(seed)} % 6;
				bus_new = 1'b0;
			end
			r_valid = 1'b0;
			if (bus_busy && bus_delay > 0)
				bus_delay--;
			else if (bus_busy && ({$random(seed)} % 4 != 0)) begin
				r_valid = 1'b1;
				r.data = mem_word(bus_line + addr_t'(8 * bus_beat));
				r.last = (bus_beat == `ICACHE_LINE_BEATS - 1);
			end
		end
	end

	task automatic fetch_line(input addr_t a);
		int idx, set_i, cycles, rises, rsps;
		logic sure, fresh, got;
		idx = pool_index(a);
		set_i = a[10:5];
		// At most two distinct lines since the fence means both still sit in the set
		sure = filled[idx] && set_fills[set_i] <= 2;
		fresh = !filled[idx];
		rises = ar_rises;
		rsps = rsp_count;
		req_valid = 1'b1;
		req_addr = a;
		cycles = 0;
		do begin
			@(posedge CLK);
			cycles++;
			got = req_ready;
		end while (!got && cycles < WAIT_LIMIT);
		@(negedge CLK);
		req_valid = 1'b0;
		n_fetch++;
		assert (got) else note_failure($sformatf("no response to fetch of %h", a));
		if (got) begin
			assert (rsp_count == rsps + 1) else note_failure("response lost or repeated");
			if (sure) begin
				assert (cycles == 2)
				else report_mismatch($sformatf("resident %h took %0d cycles", a, cycles));
				assert (ar_rises == rises) else note_failure("resident line caused a burst");
			end
			if (fresh)
				assert (ar_rises == rises + 1) else note_failure("uncached line gave no burst");
		end
		// A fetch of a line that is not resident brings it into its set
		if (!filled[idx]) begin
			filled[idx] = 1'b1;
			set_fills[set_i]++;
		end
	endtask

	task automatic apply_fence();
		int cycles, ends;
		logic got;
		ends = fence_ends;
		fence = 1'b1;
		cycles = 0;
		do begin
			@(posedge CLK);
			cycles++;
			got = fence_end;
		end while (!got && cycles < WAIT_LIMIT);
		@(negedge CLK);
		fence = 1'b0;
		n_fence++;
		// A second pulse would show up within these cycles
		repeat (2) @(negedge CLK);
		assert (got) else note_failure("fence was never answered by fence_end");
		if (got)
			assert (fence_ends == ends + 1) else note_failure("fence_end pulse count is off");
		// Nothing is resident after a fence
		for (int i = 0; i < POOL; i++)
			filled[i] = 1'b0;
		for (int s = 0; s < `ICACHE_SETS; s++)
			set_fills[s] = 0;
	endtask

	initial begin
		tag_t tag;
		int k, b;
		seed = 80;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_addr = '0;
		fence = 1'b0;
		// Eight lines over three sets so that two sets see conflicts
		for (int i = 0; i < POOL; i++) begin
			tag = {18'($random(seed)), 3'(i)};
			pool[i] = {tag, set_idx_t'(5 + 16 * (i % 3)), 5'b0};
			filled[i] = 1'b0;
		end
		for (int i = 0; i < NUM_OPS; i++) begin
			op_fence[i] = ({$random(seed)} % 20 == 0);
			k = {$random(seed)} % POOL;
			b = {$random(seed)} % `ICACHE_LINE_BEATS;
			op_addr[i] = pool[k] | addr_t'(b << 3);
		end
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
		@(posedge CLK);
		assert (!ar_valid && !r_ready && !req_ready && !rsp_valid && !fence_end)
		else report_mismatch("control outputs not low after reset");
		for (int i = 0; i < NUM_OPS; i++) begin
			@(negedge CLK);
			while (bus_busy)
				@(negedge CLK);
			if (op_fence[i])
				apply_fence();
			else
				fetch_line(op_addr[i]);
		end
		while (bus_busy)
			@(negedge CLK);
		repeat (4) @(negedge CLK);
		assert (rsp_count == n_fetch) else note_failure("total responses differ from fetches");
		assert (fence_ends == n_fence) else note_failure("total fence_end pulses differ from fences");
		$display("Checks done: %0d fetches, %0d fences, %0d mismatches, %0d other failures",
			n_fetch, n_fence, mismatches, failures);
		if (mismatches + failures == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Sixty cycles per operation is far beyond the slowest refill
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t before all operations completed", $time);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
// Free-running testbench clock, starts low

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(parameter real PERIOD_NS = 4.0) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2.0) CLK = ~CLK;
	end

endmodule

`default_nettype wire

// ==== source/icache.sv ====
// Two-way instruction cache between a fetch unit and a 64-bit read burst bus
// rsp_valid is a one-cycle pulse; the fetch unit holds req_addr until req_ready

`timescale 1ns/1ps
`default_nettype none

module icache import icache_pkg::*; (
	input logic CLK,
	input logic rst_n,
	// Fetch side
	input logic req_valid,
	input addr_t req_addr,
	output logic req_ready,
	output logic rsp_valid,
	output word_t rsp_data,
	input logic fence,
	output logic fence_end,
	// Bus side
	output logic ar_valid,
	input logic ar_ready,
	output ar_chan_t ar,
	input logic r_valid,
	output logic r_ready,
	input r_beat_t r
);

	logic tag_rd, tag_wr, clear_all, data_rd, data_wr, use_refill, lfsr_advance;
	way_vec_t hit, valid, victim, fill_way;
	beat_idx_t fill_beat;
	word_t rd_data;
	addr_t data_addr;

	icache_ctrl u_ctrl (
		.CLK(CLK), .rst_n(rst_n),
		.req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .fence(fence), .fence_end(fence_end),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
		.r_valid(r_valid), .r_ready(r_ready), .r(r),
		.tag_rd(tag_rd), .tag_wr(tag_wr), .clear_all(clear_all), .hit(hit),
		.data_rd(data_rd), .data_wr(data_wr), .fill_way(fill_way),
		.fill_beat(fill_beat), .use_refill(use_refill),
		.victim(victim), .lfsr_advance(lfsr_advance)
	);

	icache_tag_array u_tags (
		.CLK(CLK), .rst_n(rst_n), .addr(req_addr), .rd(tag_rd), .wr(tag_wr),
		.wr_way(fill_way), .clear_all(clear_all), .hit(hit), .valid(valid)
	);

	// Refill beats land in the missed line even after the fetch side moves on
	assign data_addr = use_refill ? ar.addr : req_addr;

	icache_data_array u_data (
		.CLK(CLK), .addr(data_addr), .rd(data_rd), .wr(data_wr), .wr_way(fill_way),
		.wr_beat(fill_beat), .wr_data(r.data), .hit(hit), .rd_data(rd_data)
	);

	icache_victim_sel u_victim (
		.CLK(CLK), .rst_n(rst_n), .valid(valid), .advance(lfsr_advance), .victim(victim)
	);

	// Critical beat bypasses the array during refill
	assign rsp_data = use_refill ? r.data : rd_data;

endmodule

`default_nettype wire

// ==== source/icache_victim_sel.sv ====
// Replacement choice: lowest invalid way, else a pseudo-random way
// The LFSR index uses the low bits, so the way count must be a power of two

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_victim_sel import icache_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input way_vec_t valid,
	input logic advance,
	output way_vec_t victim
);

	localparam int WAY_IDX_W = $clog2(`ICACHE_WAYS);
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	logic [15:0] lfsr_q;
	logic feedback;

	// Taps 16, 14, 13, 11 give a maximal sequence
	assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

	always_ff @(posedge CLK) begin
		if (!rst_n)
			lfsr_q <= LFSR_SEED;
		else if (advance)
			lfsr_q <= {lfsr_q[14:0], feedback};
	end

	always_comb begin
		victim = '0;
		if (&valid) begin
			victim[lfsr_q[WAY_IDX_W-1:0]] = 1'b1;
		end else begin
			// Scan downward so the lowest invalid way is kept
			for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
				if (!valid[w])
					victim = way_vec_t'(1) << w;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/icache_data_array.sv ====
// Line data store, one 64-bit word per set, way and beat
// A read returns the word of every way one cycle later; hit picks one of them

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_data_array import icache_pkg::*; (
	input logic CLK,
	input addr_t addr,
	input logic rd,
	input logic wr,
	input way_vec_t wr_way,
	input beat_idx_t wr_beat,
	input word_t wr_data,
	input way_vec_t hit,
	output word_t rd_data
);

	word_t mem [`ICACHE_WAYS][`ICACHE_SETS * `ICACHE_LINE_BEATS];
	word_t rd_q [`ICACHE_WAYS];
	logic [SET_W+BEAT_W-1:0] rd_idx, wr_idx;

	// Row is set then beat
	assign rd_idx = {addr_set(addr), addr_beat(addr)};
	assign wr_idx = {addr_set(addr), wr_beat};

	always_ff @(posedge CLK) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (wr && wr_way[w])
				mem[w][wr_idx] <= wr_data;
			if (rd)
				rd_q[w] <= mem[w][rd_idx];
		end
	end

	// One-hot way select
	always_comb begin
		rd_data = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit[w])
				rd_data = rd_data | rd_q[w];
		end
	end

endmodule

`default_nettype wire

// ==== source/icache_tag_array.sv ====
// Tag store with per-set valid bits and a registered tag read
// hit is valid only in the cycle after rd, with addr still held

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_tag_array import icache_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input addr_t addr,
	input logic rd,
	input logic wr,
	input way_vec_t wr_way,
	input logic clear_all,
	output way_vec_t hit,
	output way_vec_t valid
);

	tag_t tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
	tag_t tag_q [`ICACHE_WAYS];
	way_vec_t valid_q [`ICACHE_SETS];
	set_idx_t set;

	assign set = addr_set(addr);

	// Tag storage, write on a miss into the victim way
	always_ff @(posedge CLK) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (wr && wr_way[w])
				tag_mem[w][set] <= addr_tag(addr);
			if (rd)
				tag_q[w] <= tag_mem[w][set];
		end
	end

	// Valid bits, cleared by reset and by fence
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int s = 0; s < `ICACHE_SETS; s++)
				valid_q[s] <= '0;
		end else if (clear_all) begin
			for (int s = 0; s < `ICACHE_SETS; s++)
				valid_q[s] <= '0;
		end else if (wr) begin
			valid_q[set] <= valid_q[set] | wr_way;
		end
	end

	assign valid = valid_q[set];

	// Compare read tags against the held address
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++)
			hit[w] = valid_q[set][w] && (tag_q[w] == addr_tag(addr));
	end

endmodule

`default_nettype wire

// ==== source/icache_ctrl.sv ====
// Instruction cache controller: lookup, single-burst refill and fence
// req_addr must stay stable from req_valid until req_ready
// The response is a one-cycle pulse with no back-pressure; bus errors are ignored

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_ctrl import icache_pkg::*; (
	input logic CLK,
	input logic rst_n,
	// Fetch side
	input logic req_valid,
	input addr_t req_addr,
	output logic req_ready,
	output logic rsp_valid,
	input logic fence,
	output logic fence_end,
	// Bus side
	output logic ar_valid,
	input logic ar_ready,
	output ar_chan_t ar,
	input logic r_valid,
	output logic r_ready,
	input r_beat_t r,
	// Tag array
	output logic tag_rd,
	output logic tag_wr,
	output logic clear_all,
	input way_vec_t hit,
	// Data array
	output logic data_rd,
	output logic data_wr,
	output way_vec_t fill_way,
	output beat_idx_t fill_beat,
	output logic use_refill,
	// Victim selector
	input way_vec_t victim,
	output logic lfsr_advance
);

	icache_state_e state_q, state_d;
	way_vec_t way_q;
	beat_idx_t beat_q;
	addr_t line_addr_q;
	logic sent_q;
	logic any_hit, miss, ar_fire, r_fire, crit_beat, start;

	assign any_hit = |hit;
	assign miss = (state_q == ST_LOOKUP) && !any_hit;
	assign ar_fire = ar_valid && ar_ready;
	assign r_fire = (state_q == ST_REFILL) && r_valid && r_ready;
	// Requested doubleword arrives, forwarded only once per refill
	assign crit_beat = r_fire && (beat_q == addr_beat(req_addr)) && !sent_q;
	// Fence wins over a pending request
	assign start = (state_q == ST_IDLE) && req_valid && !fence;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (fence)
					state_d = ST_FENCE;
				else if (req_valid)
					state_d = ST_LOOKUP;
			end
			ST_LOOKUP: state_d = any_hit ? ST_IDLE : ST_REFILL;
			ST_REFILL: begin
				if (r_fire && r.last)
					state_d = ST_IDLE;
			end
			ST_FENCE: state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			ar_valid <= 1'b0;
			r_ready <= 1'b0;
			way_q <= '0;
			beat_q <= '0;
			sent_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Request flag held until the bus accepts it
			if (miss)
				ar_valid <= 1'b1;
			else if (ar_fire)
				ar_valid <= 1'b0;
			// Data flag dropped on the last beat
			if (miss)
				r_ready <= 1'b1;
			else if (r_fire && r.last)
				r_ready <= 1'b0;
			if (miss) begin
				way_q <= victim;
				beat_q <= '0;
				sent_q <= 1'b0;
			end else if (r_fire) begin
				beat_q <= beat_q + beat_idx_t'(1);
				if (crit_beat)
					sent_q <= 1'b1;
			end
		end
	end

	// Line address kept for the whole refill, fetch side may move on
	always_ff @(posedge CLK) begin
		if (miss)
			line_addr_q <= line_base(req_addr);
	end

	assign ar = '{addr: line_addr_q, len: 8'(`ICACHE_LINE_BEATS - 1), burst: BURST_INCR};

	// Hit answers in lookup, miss answers with the critical beat
	assign rsp_valid = ((state_q == ST_LOOKUP) && any_hit) || crit_beat;
	assign req_ready = rsp_valid;

	assign tag_rd = start;
	assign data_rd = start;
	assign tag_wr = miss;
	// Victim picked in lookup, latched way used for the beats
	assign fill_way = (state_q == ST_LOOKUP) ? victim : way_q;
	assign data_wr = r_fire;
	assign fill_beat = beat_q;
	assign use_refill = (state_q == ST_REFILL);
	assign lfsr_advance = (state_q == ST_LOOKUP);

	// Fence lasts one cycle
	assign clear_all = (state_q == ST_FENCE);
	assign fence_end = (state_q == ST_FENCE);

endmodule

`default_nettype wire

// ==== source/icache_pkg.sv ====
// Types, address field helpers and bus channel structs of the instruction cache
// Field widths follow the geometry macros; byte offset within a beat is 3 bits

`default_nettype none

`include "icache_params.svh"

package icache_pkg;

	localparam int BYTE_OFS_W = 3;
	localparam int BEAT_W = $clog2(`ICACHE_LINE_BEATS);
	localparam int SET_W = $clog2(`ICACHE_SETS);
	localparam int LINE_OFS_W = BYTE_OFS_W + BEAT_W;
	localparam int TAG_W = `ICACHE_ADDR_W - LINE_OFS_W - SET_W;
	// Incrementing burst code
	localparam logic [1:0] BURST_INCR = 2'b01;

	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
	typedef logic [63:0] word_t;
	typedef logic [SET_W-1:0] set_idx_t;
	typedef logic [BEAT_W-1:0] beat_idx_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_WAYS-1:0] way_vec_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_REFILL,
		ST_FENCE
	} icache_state_e;

	// Burst request channel
	typedef struct packed {
		addr_t addr;
		logic [7:0] len;
		logic [1:0] burst;
	} ar_chan_t;

	// Read data beat
	typedef struct packed {
		word_t data;
		logic last;
	} r_beat_t;

	function automatic set_idx_t addr_set(addr_t a);
		return a[LINE_OFS_W +: SET_W];
	endfunction

	function automatic beat_idx_t addr_beat(addr_t a);
		return a[BYTE_OFS_W +: BEAT_W];
	endfunction

	function automatic tag_t addr_tag(addr_t a);
		return a[`ICACHE_ADDR_W-1 -: TAG_W];
	endfunction

	// Line-aligned base of an address
	function automatic addr_t line_base(addr_t a);
		return {a[`ICACHE_ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
	endfunction

endpackage

`default_nettype wire

// ==== source/icache_params.svh ====
// Cache geometry shared by the package and the RTL
// Ways must be a power of two and at least 2; the line has a power-of-two beat count
// Beats are 64 bits wide, so the byte offset within a beat is fixed at 3 bits

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Associativity
`define ICACHE_WAYS 2
// Sets per way
`define ICACHE_SETS 64
// 64-bit beats per line, burst length is one less
`define ICACHE_LINE_BEATS 4
// Fetch and bus address width
`define ICACHE_ADDR_W 32

`endif
